/* armCtrlPkg.sv */
`default_nettype none

package armCtrlPkg;

  // ====================
  // Widths
  // ====================
  localparam int INSTR_W = 32;          // Instruction and ALU result
  localparam int OP_W    = 4;           // DP opcode field, bits 24:21

  // Instruction classes on bits 27:25
  localparam logic [2:0] CLS_DPREG  = 3'b000;
  localparam logic [2:0] CLS_DPIMM  = 3'b001;
  localparam logic [2:0] CLS_LSIMM  = 3'b010;  // I bit clear means immediate offset
  localparam logic [2:0] CLS_LSREG  = 3'b011;  // Bit 4 set is the undefined space
  localparam logic [2:0] CLS_BRANCH = 3'b101;

  // ALU opcodes used by the control path
  localparam logic [OP_W-1:0] ALU_SUB = 4'b0010;
  localparam logic [OP_W-1:0] ALU_ADD = 4'b0100;
  localparam logic [OP_W-1:0] ALU_TST = 4'b1000;
  localparam logic [OP_W-1:0] ALU_TEQ = 4'b1001;
  localparam logic [OP_W-1:0] ALU_CMP = 4'b1010;
  localparam logic [OP_W-1:0] ALU_CMN = 4'b1011;

  localparam logic [3:0] PC_REG = 4'd15;

  // ====================
  // Condition codes
  // ====================
  localparam logic [3:0] COND_EQ = 4'h0;
  localparam logic [3:0] COND_NE = 4'h1;
  localparam logic [3:0] COND_CS = 4'h2;
  localparam logic [3:0] COND_CC = 4'h3;
  localparam logic [3:0] COND_MI = 4'h4;
  localparam logic [3:0] COND_PL = 4'h5;
  localparam logic [3:0] COND_VS = 4'h6;
  localparam logic [3:0] COND_VC = 4'h7;
  localparam logic [3:0] COND_HI = 4'h8;
  localparam logic [3:0] COND_LS = 4'h9;
  localparam logic [3:0] COND_GE = 4'hA;
  localparam logic [3:0] COND_LT = 4'hB;
  localparam logic [3:0] COND_GT = 4'hC;
  localparam logic [3:0] COND_LE = 4'hD;
  localparam logic [3:0] COND_AL = 4'hE;
  localparam logic [3:0] COND_NV = 4'hF;  // Never executes here

  // ====================
  // Stage payloads
  // ====================
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // Decode to execute
  typedef struct packed {
    logic            valid;       // Instruction present
    logic [3:0]      cond;
    logic [OP_W-1:0] aluControl;
    logic            aluSrc;      // Immediate operand B
    logic            regWrite;
    logic            memWrite;
    logic            memtoReg;
    logic            branch;
    logic            pcSrc;
    logic [1:0]      flagWrite;   // {NZ, CV}
    logic            byteAccess;
  } decExec_t;

  // Execute to memory, already gated by the condition
  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    flags_t     flagsNext;
    logic       setFlags;
    logic [3:0] byteMask;
  } execMem_t;

  // Memory to writeback
  typedef struct packed {
    logic   memtoReg;
    logic   regWrite;
    logic   pcSrc;
    flags_t flagsNext;
    logic   setFlags;
  } memWb_t;

  // Output bundles
  typedef struct packed {
    logic [OP_W-1:0] aluControl;
    logic            aluSrc;
    logic            branchTaken;
    flags_t          flagsE;      // Forwarded NZCV
  } exCtrl_t;

  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic [3:0] byteMask;
  } memCtrl_t;

  typedef struct packed {
    logic memtoReg;
    logic regWrite;
    logic pcSrc;
  } wbCtrl_t;

endpackage

`default_nettype wire

/* ctrlDecoder.sv */
`timescale 1ns/100ps
`default_nettype none

module ctrlDecoder (
  input  logic [armCtrlPkg::INSTR_W-1:0] instrD,
  input  logic                           instrValidD,
  output armCtrlPkg::decExec_t           decCtrl
);

  import armCtrlPkg::*;

  // ====================
  // Instruction fields
  // ====================
  logic [2:0]      instrClass;
  logic [OP_W-1:0] dpOpcode;
  logic [3:0]      rd;
  logic            sBit;
  logic            uBit;
  logic            bBit;
  logic            lBit;
  logic            iBit;

  logic            isDp;
  logic            isLdrStr;
  logic            isBranch;
  logic            isTest;
  logic            isArith;

  decExec_t        ctrl;

  assign instrClass = instrD[27:25];
  assign dpOpcode   = instrD[24:21];
  assign rd         = instrD[15:12];  // Destination register
  assign sBit       = instrD[20];     // Set flags on DP
  assign lBit       = instrD[20];     // Load on LDR/STR, same position as S
  assign uBit       = instrD[23];     // Add offset when set
  assign bBit       = instrD[22];     // Byte access
  assign iBit       = instrD[25];     // Register offset for LDR/STR

  // Class decode
  always_comb begin
    isDp     = 1'b0;
    isLdrStr = 1'b0;
    isBranch = 1'b0;
    case (instrClass)
      CLS_DPREG,
      CLS_DPIMM:  isDp = 1'b1;
      CLS_LSIMM:  isLdrStr = 1'b1;
      CLS_LSREG:  isLdrStr = ~instrD[4];  // Bit 4 set falls into undefined
      CLS_BRANCH: isBranch = 1'b1;
      default:    isDp = 1'b0;            // LDM/STM, coprocessor, SWI
    endcase
  end

  // Compare and test ops only touch the flags
  assign isTest  = dpOpcode inside {ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN};

  // SUB through RSC plus CMP and CMN produce real C and V
  assign isArith = dpOpcode inside {[4'b0010:4'b0111], ALU_CMP, ALU_CMN};

  // ====================
  // Control formation
  // ====================
  always_comb begin
    ctrl            = '0;
    ctrl.valid      = 1'b1;
    ctrl.cond       = instrD[31:28];
    ctrl.aluControl = ALU_ADD;  // Default for branch and unknown patterns
    if (isDp) begin
      ctrl.aluControl = dpOpcode;
      ctrl.aluSrc     = (instrClass == CLS_DPIMM);
      ctrl.regWrite   = ~isTest;
      ctrl.flagWrite  = {sBit, sBit & isArith};  // Logical ops leave C and V alone
    end else if (isLdrStr) begin
      ctrl.aluControl = uBit ? ALU_ADD : ALU_SUB;  // Base plus or minus offset
      ctrl.aluSrc     = ~iBit;                     // Inverted sense for loads and stores
      ctrl.regWrite   = lBit;
      ctrl.memtoReg   = lBit;
      ctrl.memWrite   = ~lBit;
      ctrl.byteAccess = bBit;
    end else if (isBranch) begin
      ctrl.aluSrc = 1'b1;  // PC plus offset
      ctrl.branch = 1'b1;
    end

    // PC gets written by a branch or by any register write to R15
    ctrl.pcSrc = ((rd == PC_REG) & ctrl.regWrite) | ctrl.branch;
  end

  // Bubbles carry an all-zero payload
  assign decCtrl = instrValidD ? ctrl : '0;

endmodule

`default_nettype wire

/* stageReg.sv */
`timescale 1ns/100ps
`default_nettype none

// One register per stage boundary
// The payload struct carries its own valid and control bits
module stageReg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arstN,
  input  payload_t d,
  output payload_t q
);

  // ====================
  // Stage flop
  // ====================
  // No stall or flush so the pipeline moves every cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q <= '0;  // Clears valid and every write enable
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* execCond.sv */
`timescale 1ns/100ps
`default_nettype none

module execCond (
  input  armCtrlPkg::decExec_t decCtrlE,
  input  armCtrlPkg::flags_t   flagsE,     // Forwarded NZCV
  input  armCtrlPkg::flags_t   aluFlagsE,  // Result flags of this instruction
  input  logic [1:0]           addrLow,
  output armCtrlPkg::exCtrl_t  exCtrl,
  output armCtrlPkg::execMem_t memCtrl
);

  import armCtrlPkg::*;

  logic       condEx;
  flags_t     flagsNext;
  logic [3:0] byteMask;

  // ====================
  // Condition check
  // ====================
  always_comb begin
    case (decCtrlE.cond)
      COND_EQ: condEx = flagsE.z;
      COND_NE: condEx = ~flagsE.z;
      COND_CS: condEx = flagsE.c;
      COND_CC: condEx = ~flagsE.c;
      COND_MI: condEx = flagsE.n;
      COND_PL: condEx = ~flagsE.n;
      COND_VS: condEx = flagsE.v;
      COND_VC: condEx = ~flagsE.v;
      COND_HI: condEx = flagsE.c & ~flagsE.z;
      COND_LS: condEx = ~flagsE.c | flagsE.z;
      COND_GE: condEx = (flagsE.n == flagsE.v);
      COND_LT: condEx = (flagsE.n != flagsE.v);
      COND_GT: condEx = ~flagsE.z & (flagsE.n == flagsE.v);
      COND_LE: condEx = flagsE.z | (flagsE.n != flagsE.v);
      COND_AL: condEx = 1'b1;
      COND_NV: condEx = 1'b0;
      default: condEx = 1'b0;
    endcase
  end

  // Split flag update
  // Unwritten flags keep the forwarded values
  always_comb begin
    flagsNext = flagsE;
    if (decCtrlE.flagWrite[1]) begin
      flagsNext.n = aluFlagsE.n;
      flagsNext.z = aluFlagsE.z;
    end
    if (decCtrlE.flagWrite[0]) begin
      flagsNext.c = aluFlagsE.c;
      flagsNext.v = aluFlagsE.v;
    end
  end

  // One lane per byte store, all lanes for a word
  assign byteMask = decCtrlE.byteAccess ? (4'b0001 << addrLow) : 4'b1111;

  // ====================
  // Outputs
  // ====================
  assign exCtrl.aluControl  = decCtrlE.aluControl;
  assign exCtrl.aluSrc      = decCtrlE.aluSrc;
  assign exCtrl.branchTaken = decCtrlE.branch & condEx;
  assign exCtrl.flagsE      = flagsE;

  always_comb begin
    memCtrl = '0;  // Bubble stays all zero
    if (decCtrlE.valid) begin
      memCtrl.memWrite  = decCtrlE.memWrite & condEx;
      memCtrl.memtoReg  = decCtrlE.memtoReg & condEx;
      memCtrl.regWrite  = decCtrlE.regWrite & condEx;
      memCtrl.pcSrc     = decCtrlE.pcSrc & condEx;
      memCtrl.flagsNext = flagsNext;
      memCtrl.setFlags  = (|decCtrlE.flagWrite) & condEx;
      memCtrl.byteMask  = byteMask;
    end
  end

endmodule

`default_nettype wire

/* flagFile.sv */
`timescale 1ns/100ps
`default_nettype none

module flagFile (
  input  logic                 clk,
  input  logic                 arstN,
  input  armCtrlPkg::execMem_t memFlags,  // Memory stage register
  input  armCtrlPkg::memWb_t   wbFlags,   // Writeback stage register
  output armCtrlPkg::flags_t   flagsE
);

  import armCtrlPkg::*;

  flags_t flagsQ;  // Architectural NZCV

  // ====================
  // NZCV register
  // ====================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagsQ <= '0;
    end else if (wbFlags.setFlags) begin
      flagsQ <= wbFlags.flagsNext;  // Commit in writeback
    end
  end

  // ====================
  // Forwarding
  // ====================
  // Newest pending update wins
  // Memory stage is younger than writeback
  always_comb begin
    if (memFlags.setFlags) begin
      flagsE = memFlags.flagsNext;
    end else if (wbFlags.setFlags) begin
      flagsE = wbFlags.flagsNext;
    end else begin
      flagsE = flagsQ;
    end
  end

endmodule

`default_nettype wire

/* armCtrl.sv */
`timescale 1ns/100ps
`default_nettype none

module armCtrl (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic                           instrValidD,
  input  logic [armCtrlPkg::INSTR_W-1:0] instrD,
  input  armCtrlPkg::flags_t             aluFlagsE,
  input  logic [1:0]                     aluResultE,  // Low address bits
  output armCtrlPkg::exCtrl_t            exCtrlE,
  output armCtrlPkg::memCtrl_t           memCtrlM,
  output armCtrlPkg::wbCtrl_t            wbCtrlW
);

  import armCtrlPkg::*;

  decExec_t decCtrlD;   // Decoder output
  decExec_t decCtrlE;   // Held for execute
  execMem_t execMemE;   // Gated execute result
  execMem_t execMemM;
  memWb_t   memWbM;     // Slice passed on to writeback
  memWb_t   memWbW;
  flags_t   flagsE;

  // ====================
  // Decode
  // ====================
  ctrlDecoder decoder (
    .instrD      (instrD),
    .instrValidD (instrValidD),
    .decCtrl     (decCtrlD)
  );

  stageReg #(.payload_t(decExec_t)) regDE (
    .clk   (clk),
    .arstN (arstN),
    .d     (decCtrlD),
    .q     (decCtrlE)
  );

  // ====================
  // Execute
  // ====================
  execCond execUnit (
    .decCtrlE  (decCtrlE),
    .flagsE    (flagsE),
    .aluFlagsE (aluFlagsE),
    .addrLow   (aluResultE),
    .exCtrl    (exCtrlE),
    .memCtrl   (execMemE)
  );

  stageReg #(.payload_t(execMem_t)) regEM (
    .clk   (clk),
    .arstN (arstN),
    .d     (execMemE),
    .q     (execMemM)
  );

  // ====================
  // Memory
  // ====================
  assign memCtrlM.memWrite = execMemM.memWrite;
  assign memCtrlM.memtoReg = execMemM.memtoReg;
  assign memCtrlM.regWrite = execMemM.regWrite;
  assign memCtrlM.byteMask = execMemM.byteMask;

  // Byte mask stops here
  assign memWbM.memtoReg  = execMemM.memtoReg;
  assign memWbM.regWrite  = execMemM.regWrite;
  assign memWbM.pcSrc     = execMemM.pcSrc;
  assign memWbM.flagsNext = execMemM.flagsNext;
  assign memWbM.setFlags  = execMemM.setFlags;

  stageReg #(.payload_t(memWb_t)) regMW (
    .clk   (clk),
    .arstN (arstN),
    .d     (memWbM),
    .q     (memWbW)
  );

  // ====================
  // Writeback
  // ====================
  assign wbCtrlW.memtoReg = memWbW.memtoReg;
  assign wbCtrlW.regWrite = memWbW.regWrite;
  assign wbCtrlW.pcSrc    = memWbW.pcSrc;

  flagFile flagRegs (
    .clk      (clk),
    .arstN    (arstN),
    .memFlags (execMemM),
    .wbFlags  (memWbW),
    .flagsE   (flagsE)
  );

endmodule

`default_nettype wire

/* tb_armCtrl.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_armCtrl;

  import armCtrlPkg::*;

  // Ungated decode expectation for one table entry
  typedef struct packed {
    logic       aluSrc;
    logic       regWrite;
    logic       memWrite;
    logic       memtoReg;
    logic       branch;
    logic       pcSrc;
    logic [1:0] flagWrite;  // {NZ, CV}
    logic       byteAcc;
  } ctrlExp_t;

  typedef struct packed {
    logic            valid;     // Low for a bubble
    logic [31:0]     instr;
    flags_t          aluFlags;  // Driven one cycle after the instruction
    logic [1:0]      addr;
    logic [OP_W-1:0] aluCtl;
    ctrlExp_t        ctrl;
  } row_t;

  logic               clk;
  logic               arstN;
  logic               instrValidD;
  logic [INSTR_W-1:0] instrD;
  flags_t             aluFlagsE;
  logic [1:0]         aluResultE;
  exCtrl_t            exCtrlE;
  memCtrl_t           memCtrlM;
  wbCtrl_t            wbCtrlW;

  row_t     rows[$];
  exCtrl_t  expEx[$];   // Seen one cycle after decode
  memCtrl_t expMem[$];  // Two cycles
  wbCtrl_t  expWb[$];   // Three cycles
  int       cycleCount = 0;
  int       seedVal;

  armCtrl u_armCtrl (
    .clk         (clk),
    .arstN       (arstN),
    .instrValidD (instrValidD),
    .instrD      (instrD),
    .aluFlagsE   (aluFlagsE),
    .aluResultE  (aluResultE),
    .exCtrlE     (exCtrlE),
    .memCtrlM    (memCtrlM),
    .wbCtrlW     (wbCtrlW)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // ====================
  // Failure handling
  // ====================
  task automatic abortRun(string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Stopped at first error");
  endtask

  function automatic string errLine(string name, logic [15:0] expV, logic [15:0] gotV, int k);
    return $sformatf("ERR t=%0t %s expected %h got %h (%s)", $time, name, expV, gotV,
                     (k < 0) ? "reset" : $sformatf("entry %0d", k));
  endfunction

  // Table length plus slack
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > rows.size() + 20) begin
      abortRun("Timeout: the run went past the expected number of cycles");
    end
  end

  // ====================
  // Instruction builders
  // ====================
  function automatic logic [3:0] randReg();
    return 4'($urandom_range(14));  // Any register but the PC
  endfunction

  function automatic logic [31:0] dpInstr(logic [3:0] cond, logic [3:0] op, logic imm, logic s);
    logic [31:0] w;
    w        = $urandom;  // Rn and operand 2
    w[31:28] = cond;
    w[27:25] = imm ? 3'b001 : 3'b000;
    w[24:21] = op;
    w[20]    = s;
    w[15:12] = randReg();
    if (!imm) w[4] = 1'b0;  // Shift by immediate
    return w;
  endfunction

  function automatic logic [31:0] lsInstr(logic [3:0] cond, logic load, logic byteAcc,
                                          logic up, logic regOff);
    logic [31:0] w;
    w        = $urandom;
    w[31:28] = cond;
    w[27:25] = regOff ? 3'b011 : 3'b010;
    w[24]    = 1'b1;     // Pre-indexed
    w[23]    = up;
    w[22]    = byteAcc;
    w[21]    = 1'b0;     // No base writeback
    w[20]    = load;
    w[15:12] = randReg();
    if (regOff) w[4] = 1'b0;  // Stay out of the undefined space
    return w;
  endfunction

  function automatic logic [31:0] brInstr(logic [3:0] cond);
    logic [31:0] w;
    w        = $urandom;  // Random offset
    w[31:28] = cond;
    w[27:25] = 3'b101;
    return w;
  endfunction

  // Undefined, block transfer or coprocessor space
  function automatic logic [31:0] otherInstr(logic [2:0] cls);
    logic [31:0] w;
    w        = $urandom;
    w[31:28] = COND_AL;
    w[27:25] = cls;
    w[4]     = 1'b1;
    return w;
  endfunction

  function automatic logic [31:0] toPc(logic [31:0] instr);
    logic [31:0] w;
    w        = instr;
    w[15:12] = PC_REG;
    return w;
  endfunction

  // ====================
  // Table and reference model
  // ====================
  task automatic addRow(logic [31:0] instr, flags_t aluFlags, logic [1:0] addr,
                        logic [OP_W-1:0] aluCtl, ctrlExp_t ctrl);
    row_t r;
    r.valid    = 1'b1;
    r.instr    = instr;
    r.aluFlags = aluFlags;
    r.addr     = addr;
    r.aluCtl   = aluCtl;
    r.ctrl     = ctrl;
    rows.push_back(r);
  endtask

  task automatic addBubble();
    row_t r;
    r       = '0;
    r.instr = $urandom;  // Junk on the bus with the strobe low
    rows.push_back(r);
  endtask

  // Even codes test a flag and odd codes invert the result
  function automatic logic condPasses(logic [3:0] cond, flags_t f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c && !f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = !f.z && (f.n == f.v);
      default: base = 1'b1;  // AL passes and NV fails after inversion
    endcase
    return cond[0] ? !base : base;
  endfunction

  task automatic buildTable();
    repeat (3) addBubble();  // Idle pipeline out of reset

    // ctrl = {aluSrc, regWrite, memWrite, memtoReg, branch, pcSrc, flagWrite, byteAcc}
    // Data processing with each result forwarded to the next entry
    addRow(dpInstr(COND_AL, ALU_ADD, 1'b1, 1'b1), 4'b1001, 2'd0, ALU_ADD, 9'b1_1_0_0_0_0_11_0);
    addRow(dpInstr(COND_AL, 4'h0, 1'b0, 1'b1), 4'b0110, 2'd0, 4'h0, 9'b0_1_0_0_0_0_10_0);  // ANDS
    addRow(dpInstr(COND_AL, ALU_SUB, 1'b1, 1'b1), 4'b0010, 2'd0, ALU_SUB, 9'b1_1_0_0_0_0_11_0);
    addRow(dpInstr(COND_AL, ALU_CMP, 1'b0, 1'b1), 4'b0110, 2'd0, ALU_CMP, 9'b0_0_0_0_0_0_11_0);
    addRow(dpInstr(COND_AL, ALU_TST, 1'b1, 1'b1), 4'b1000, 2'd0, ALU_TST, 9'b1_0_0_0_0_0_10_0);
    addRow(dpInstr(COND_AL, ALU_ADD, 1'b0, 1'b0), 4'b1111, 2'd0, ALU_ADD, 9'b0_1_0_0_0_0_00_0);
    addRow(dpInstr(COND_EQ, 4'hC, 1'b1, 1'b0), 4'b0000, 2'd0, 4'hC, 9'b1_1_0_0_0_0_00_0);  // ORREQ

    // All sixteen codes on conditional ADDS with random result flags
    for (int cc = 0; cc < 16; cc++) begin
      addRow(dpInstr(4'(cc), ALU_ADD, 1'b1, 1'b1), 4'($urandom), 2'd0, ALU_ADD,
             9'b1_1_0_0_0_0_11_0);
    end

    // Random flags from CMP then a branch and a byte store on each code
    for (int cc = 0; cc < 16; cc++) begin
      addRow(dpInstr(COND_AL, ALU_CMP, 1'b0, 1'b1), 4'($urandom), 2'd0, ALU_CMP,
             9'b0_0_0_0_0_0_11_0);
      addRow(brInstr(4'(cc)), 4'b0000, 2'd0, ALU_ADD, 9'b1_0_0_0_1_1_00_0);
      addRow(lsInstr(4'(cc), 1'b0, 1'b1, 1'b1, 1'b0), 4'b0000, 2'($urandom), ALU_ADD,
             9'b1_0_1_0_0_0_00_1);
    end

    // Loads and stores
    addRow(lsInstr(COND_AL, 1'b0, 1'b0, 1'b1, 1'b0), 4'b0000, 2'd1, ALU_ADD,
           9'b1_0_1_0_0_0_00_0);  // STR imm up
    addRow(lsInstr(COND_AL, 1'b0, 1'b0, 1'b0, 1'b1), 4'b0000, 2'd3, ALU_SUB,
           9'b0_0_1_0_0_0_00_0);  // STR reg down
    for (int a = 0; a < 4; a++) begin
      addRow(lsInstr(COND_AL, 1'b0, 1'b1, 1'b1, 1'b0), 4'b0000, 2'(a), ALU_ADD,
             9'b1_0_1_0_0_0_00_1);  // One lane per address
    end
    addRow(lsInstr(COND_AL, 1'b0, 1'b1, 1'b0, 1'b1), 4'b0000, 2'd1, ALU_SUB,
           9'b0_0_1_0_0_0_00_1);  // STRB reg down
    addRow(lsInstr(COND_AL, 1'b1, 1'b0, 1'b0, 1'b0), 4'b0000, 2'd0, ALU_SUB,
           9'b1_1_0_1_0_0_00_0);  // LDR imm down
    addRow(lsInstr(COND_AL, 1'b1, 1'b1, 1'b1, 1'b1), 4'b0000, 2'd2, ALU_ADD,
           9'b0_1_0_1_0_0_00_1);  // LDRB reg up

    // Branch and writes to the PC
    addRow(brInstr(COND_AL), 4'b0000, 2'd0, ALU_ADD, 9'b1_0_0_0_1_1_00_0);
    addRow(toPc(dpInstr(COND_AL, 4'hD, 1'b1, 1'b0)), 4'b0000, 2'd0, 4'hD,
           9'b1_1_0_0_0_1_00_0);  // MOV pc
    addRow(toPc(dpInstr(COND_AL, 4'hD, 1'b0, 1'b1)), 4'b0100, 2'd0, 4'hD,
           9'b0_1_0_0_0_1_10_0);  // MOVS pc
    addRow(toPc(dpInstr(COND_AL, ALU_CMP, 1'b0, 1'b1)), 4'b0011, 2'd0, ALU_CMP,
           9'b0_0_0_0_0_0_11_0);  // Rd field ignored
    addRow(toPc(dpInstr(COND_NE, 4'hD, 1'b1, 1'b0)), 4'b0000, 2'd0, 4'hD,
           9'b1_1_0_0_0_1_00_0);

    // Undefined and unsupported classes write nothing
    addRow(otherInstr(3'b011), 4'b1111, 2'd0, ALU_ADD, 9'b0_0_0_0_0_0_00_0);
    addRow(otherInstr(3'b100), 4'b1111, 2'd0, ALU_ADD, 9'b0_0_0_0_0_0_00_0);
    addRow(otherInstr(3'b111), 4'b1111, 2'd0, ALU_ADD, 9'b0_0_0_0_0_0_00_0);
    repeat (3) addBubble();
  endtask

  // In-order NZCV that forwarding must reproduce
  task automatic buildExpected();
    flags_t   model;
    row_t     r;
    logic     ok;
    exCtrl_t  ex;
    memCtrl_t mem;
    wbCtrl_t  wb;
    model = '0;
    foreach (rows[k]) begin
      r  = rows[k];
      ok = r.valid && condPasses(r.instr[31:28], model);
      ex.aluControl  = r.aluCtl;
      ex.aluSrc      = r.ctrl.aluSrc;
      ex.branchTaken = r.ctrl.branch & ok;
      ex.flagsE      = model;  // Flags left by all older entries
      mem.memWrite   = r.ctrl.memWrite & ok;
      mem.memtoReg   = r.ctrl.memtoReg & ok;
      mem.regWrite   = r.ctrl.regWrite & ok;
      mem.byteMask   = 4'b0000;  // No lanes for a bubble
      if (r.valid && r.ctrl.byteAcc) mem.byteMask[r.addr] = 1'b1;
      else if (r.valid) mem.byteMask = 4'b1111;
      wb.memtoReg = r.ctrl.memtoReg & ok;
      wb.regWrite = r.ctrl.regWrite & ok;
      wb.pcSrc    = r.ctrl.pcSrc & ok;
      if (ok && r.ctrl.flagWrite[1]) begin
        model.n = r.aluFlags.n;
        model.z = r.aluFlags.z;
      end
      if (ok && r.ctrl.flagWrite[0]) begin
        model.c = r.aluFlags.c;
        model.v = r.aluFlags.v;
      end
      expEx.push_back(ex);
      expMem.push_back(mem);
      expWb.push_back(wb);
    end
  endtask

  // ====================
  // Drive and check
  // ====================
  task automatic driveInputs(int c);
    if (c < rows.size()) begin
      instrValidD = rows[c].valid;
      instrD      = rows[c].instr;
    end else begin
      instrValidD = 1'b0;
      instrD      = '0;
    end
    if (c >= 1 && c <= rows.size()) begin
      aluFlagsE  = rows[c-1].aluFlags;  // Entry now in execute
      aluResultE = rows[c-1].addr;
    end
  endtask

  task automatic checkReset();
    assert (exCtrlE === '0) else abortRun(errLine("exCtrlE", 16'd0, {6'd0, exCtrlE}, -1));
    assert (memCtrlM === '0) else abortRun(errLine("memCtrlM", 16'd0, {9'd0, memCtrlM}, -1));
    assert (wbCtrlW === '0) else abortRun(errLine("wbCtrlW", 16'd0, {13'd0, wbCtrlW}, -1));
  endtask

  task automatic checkStages(int c);
    int n;
    n = rows.size();
    if (c >= 1 && c - 1 < n) begin
      assert (exCtrlE === expEx[c-1])
        else abortRun(errLine("exCtrlE", {6'd0, expEx[c-1]}, {6'd0, exCtrlE}, c - 1));
    end
    if (c >= 2 && c - 2 < n) begin
      assert (memCtrlM === expMem[c-2])
        else abortRun(errLine("memCtrlM", {9'd0, expMem[c-2]}, {9'd0, memCtrlM}, c - 2));
    end
    if (c >= 3) begin
      assert (wbCtrlW === expWb[c-3])
        else abortRun(errLine("wbCtrlW", {13'd0, expWb[c-3]}, {13'd0, wbCtrlW}, c - 3));
    end
  endtask

  initial begin
    seedVal     = $urandom(50754);
    arstN       = 1'b0;
    instrValidD = 1'b0;
    instrD      = '0;
    aluFlagsE   = '0;
    aluResultE  = 2'd0;
    buildTable();
    buildExpected();
    repeat (4) @(posedge clk);
    #1;
    checkReset();
    arstN = 1'b1;
    for (int c = 0; c < rows.size() + 3; c++) begin
      @(posedge clk);
      #1 driveInputs(c);
      #3 checkStages(c);  // Falling edge with all stages settled
    end
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
armCtrlPkg.sv
ctrlDecoder.sv
stageReg.sv
execCond.sv
flagFile.sv
armCtrl.sv
tb_armCtrl.sv

/* Bender.yml */
package:
  name: arm_ctrl

sources:
  - armCtrlPkg.sv
  - ctrlDecoder.sv
  - stageReg.sv
  - execCond.sv
  - flagFile.sv
  - armCtrl.sv
  - target: test
    files:
      - tb_armCtrl.sv
